/* hw/regex_pkg.sv */
`default_nettype none

package regex_pkg;

   // One input byte
   typedef logic [7:0] char_t;

   // Keyword progress, k means the first k letters were seen
   typedef logic [3:0] dfa_state_t;

   // Keyword to find in every stream
   localparam int KEYWORD_LEN = 7;
   localparam logic [8*KEYWORD_LEN-1:0] KEYWORD = "torrent";

   // First letter, the only fallback target on a mismatch
   localparam char_t KEYWORD_FIRST = KEYWORD[8*KEYWORD_LEN-1 -: 8];

   // Nothing matched yet
   localparam dfa_state_t DFA_IDLE = '0;
   // Whole keyword seen
   localparam dfa_state_t DFA_ACCEPT = dfa_state_t'(KEYWORD_LEN);

endpackage

`default_nettype wire

/* hw/stream_pkg.sv */
`default_nettype none

package stream_pkg;

   // Interleaved flows, one DFA context each
   localparam int NUM_STREAMS = 64;
   typedef logic [$clog2(NUM_STREAMS)-1:0] stream_id_t;

   // Matched packet counter, wraps
   typedef logic [15:0] match_count_t;

   // One enable bit per stream
   typedef logic [NUM_STREAMS-1:0] enable_mask_t;

   // AXI4-Lite register port
   localparam int CSR_DATA_W = 32;
   typedef logic [7:0]            csr_addr_t;
   typedef logic [CSR_DATA_W-1:0] csr_data_t;
   localparam logic [1:0] AXI_OKAY = 2'b00;

   // Register map
   localparam csr_addr_t ADDR_EN_LO = 8'h00;
   localparam csr_addr_t ADDR_EN_HI = 8'h04;
   localparam csr_addr_t ADDR_COUNT = 8'h08;

endpackage

`default_nettype wire

/* hw/pkt_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pkt_if;
   import regex_pkg::*;
   import stream_pkg::*;

   // Restore pulse at packet start, new_stream picks state zero
   logic       load_state;
   logic       new_stream;
   // Held from sop until the next packet
   stream_id_t stream;
   // Scheduled character
   logic       char_vld;
   char_t      char;
   // End of packet, one cycle after the last character
   logic       eop;

   modport src (
      output load_state, new_stream, stream, char_vld, char, eop
   );

   modport dst (
      input load_state, new_stream, stream, char_vld, char, eop
   );

endinterface

`default_nettype wire

/* hw/keyword_dfa.sv */
`timescale 1ns/1ps
`default_nettype none

module keyword_dfa (
   input  logic                  clk,
   input  logic                  rst_n,
   input  regex_pkg::char_t      char_in,
   input  logic                  char_in_vld,
   input  regex_pkg::dfa_state_t state_in,
   input  logic                  state_in_vld,
   output regex_pkg::dfa_state_t state_out,
   output logic                  accept_out
);
   import regex_pkg::*;

   dfa_state_t base_state;
   dfa_state_t next_state;
   char_t      expect_char;

   always_comb
   begin
      // A restored state overrides the running one
      base_state = state_in_vld ? state_in : state_out;
      // After a full match step on as from idle
      if (base_state >= DFA_ACCEPT)
         base_state = DFA_IDLE;
      // Letter that advances from here
      expect_char = KEYWORD[8*(KEYWORD_LEN-1-int'(base_state)) +: 8];
      if (char_in == expect_char)
         next_state = base_state + 1'b1;
      else if (char_in == KEYWORD_FIRST)
         // Mismatch on a 't' may still start a new keyword
         next_state = dfa_state_t'(1);
      else
         next_state = DFA_IDLE;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out  <= DFA_IDLE;
         accept_out <= 1'b0;
      end
      else
      begin
         accept_out <= 1'b0;
         if (char_in_vld)
         begin
            state_out  <= next_state;
            // Accept pulses for the cycle the last letter lands
            accept_out <= (next_state == DFA_ACCEPT);
         end
         else if (state_in_vld)
            state_out <= state_in;
      end
   end

endmodule

`default_nettype wire

/* hw/category_matcher.sv */
`timescale 1ns/1ps
`default_nettype none

module category_matcher (
   input  logic                     clk,
   input  logic                     rst_n,
   pkt_if.dst                       pkt,
   input  stream_pkg::enable_mask_t enable_mask,
   output stream_pkg::match_count_t count,
   output logic                     pkt_done,
   output logic                     pkt_hit,
   output stream_pkg::stream_id_t   pkt_stream
);
   import regex_pkg::*;
   import stream_pkg::*;

   // Saved DFA progress per stream
   dfa_state_t state_mem [NUM_STREAMS];

   dfa_state_t restore_state;
   logic       restore_vld;
   dfa_state_t dfa_state;
   logic       dfa_accept;
   logic       match_flag;
   logic       stream_en;
   logic       hit_now;

   assign stream_en = enable_mask[pkt.stream];
   // Last character's accept lands in the eop cycle itself
   assign hit_now = match_flag | dfa_accept;

   // Restore reaches the DFA together with the first character
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         restore_vld <= 1'b0;
      else
         restore_vld <= pkt.load_state;
   end

   always_ff @(posedge clk)
   begin
      if (pkt.load_state)
         restore_state <= pkt.new_stream ? DFA_IDLE : state_mem[pkt.stream];
      // Disabled streams keep their old context
      if (pkt.eop && stream_en)
         state_mem[pkt.stream] <= dfa_state;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         match_flag <= 1'b0;
         count      <= '0;
      end
      else
      begin
         // Sticky per packet
         if (pkt.load_state)
            match_flag <= 1'b0;
         else if (dfa_accept)
            match_flag <= 1'b1;
         if (pkt.eop && stream_en && hit_now)
            count <= count + match_count_t'(1);
      end
   end

   // Packet verdict
   assign pkt_done   = pkt.eop;
   assign pkt_hit    = pkt.eop & stream_en & hit_now;
   assign pkt_stream = pkt.stream;

   keyword_dfa u_keyword_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (pkt.char),
      .char_in_vld  (pkt.char_vld),
      .state_in     (restore_state),
      .state_in_vld (restore_vld),
      .state_out    (dfa_state),
      .accept_out   (dfa_accept)
   );

endmodule

`default_nettype wire

/* hw/stream_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_tracker (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  logic                   in_sop,
   input  logic                   in_eop,
   input  regex_pkg::char_t       in_char,
   input  stream_pkg::stream_id_t in_stream,
   output logic                   in_ready,
   pkt_if.src                     pkt
);
   import regex_pkg::*;
   import stream_pkg::*;

   logic                   accept;
   logic                   out_of_rst;
   // Streams that had a packet since reset
   logic [NUM_STREAMS-1:0] seen;
   logic                   vld_d1;
   char_t                  char_d1;
   // Eop delay line, also the two-cycle gap after a packet
   logic [1:0]             eop_d;

   assign in_ready = out_of_rst & ~(|eop_d);
   assign accept   = in_valid & in_ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         out_of_rst     <= 1'b0;
         seen           <= '0;
         pkt.load_state <= 1'b0;
         vld_d1         <= 1'b0;
         pkt.char_vld   <= 1'b0;
         eop_d          <= '0;
         pkt.eop        <= 1'b0;
      end
      else
      begin
         out_of_rst     <= 1'b1;
         // Load one cycle after sop
         pkt.load_state <= accept & in_sop;
         if (accept && in_sop)
            seen[in_stream] <= 1'b1;
         // Character two cycles after its beat
         vld_d1       <= accept;
         pkt.char_vld <= vld_d1;
         // Eop three cycles after its beat
         eop_d   <= {eop_d[0], accept & in_eop};
         pkt.eop <= eop_d[1];
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept && in_sop)
      begin
         pkt.stream     <= in_stream;
         pkt.new_stream <= ~seen[in_stream];
      end
      char_d1  <= in_char;
      pkt.char <= char_d1;
   end

endmodule

`default_nettype wire

/* hw/category_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module category_csr (
   input  logic                     clk,
   input  logic                     rst_n,
   input  stream_pkg::csr_addr_t    awaddr,
   input  logic                     awvalid,
   output logic                     awready,
   input  stream_pkg::csr_data_t    wdata,
   input  logic                     wvalid,
   output logic                     wready,
   output logic [1:0]               bresp,
   output logic                     bvalid,
   input  logic                     bready,
   input  stream_pkg::csr_addr_t    araddr,
   input  logic                     arvalid,
   output logic                     arready,
   output stream_pkg::csr_data_t    rdata,
   output logic [1:0]               rresp,
   output logic                     rvalid,
   input  logic                     rready,
   input  stream_pkg::match_count_t count,
   output stream_pkg::enable_mask_t enable_mask
);
   import stream_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_WRESP, S_RDATA} csr_state_t;

   csr_state_t state;
   logic       aw_got;
   logic       w_got;
   csr_addr_t  aw_q;
   csr_data_t  w_q;
   logic       aw_hs;
   logic       w_hs;
   logic       ar_hs;
   logic       wr_go;
   csr_addr_t  wr_addr;
   csr_data_t  wr_data;
   csr_data_t  rd_data;

   // Address and data may arrive in either order
   assign awready = (state == S_IDLE) & ~aw_got;
   assign wready  = (state == S_IDLE) & ~w_got;
   // Writes take priority, a read waits for a clear write channel
   assign arready = (state == S_IDLE) & ~aw_got & ~w_got & ~awvalid & ~wvalid;

   assign aw_hs = awvalid & awready;
   assign w_hs  = wvalid & wready;
   assign ar_hs = arvalid & arready;

   assign wr_addr = aw_got ? aw_q : awaddr;
   assign wr_data = w_got ? w_q : wdata;
   assign wr_go   = (state == S_IDLE) & (aw_got | aw_hs) & (w_got | w_hs);

   assign bvalid = (state == S_WRESP);
   assign rvalid = (state == S_RDATA);
   assign bresp  = AXI_OKAY;
   assign rresp  = AXI_OKAY;

   // Read decode, unmapped reads zero
   always_comb
   begin
      case (araddr)
         ADDR_EN_LO: rd_data = enable_mask[0 +: CSR_DATA_W];
         ADDR_EN_HI: rd_data = enable_mask[CSR_DATA_W +: CSR_DATA_W];
         ADDR_COUNT: rd_data = csr_data_t'(count);
         default:    rd_data = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state       <= S_IDLE;
         aw_got      <= 1'b0;
         w_got       <= 1'b0;
         enable_mask <= '0;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               if (wr_go)
               begin
                  aw_got <= 1'b0;
                  w_got  <= 1'b0;
                  state  <= S_WRESP;
                  // Counter is read only
                  case (wr_addr)
                     ADDR_EN_LO: enable_mask[0 +: CSR_DATA_W] <= wr_data;
                     ADDR_EN_HI: enable_mask[CSR_DATA_W +: CSR_DATA_W] <= wr_data;
                     default:    ;
                  endcase
               end
               else
               begin
                  if (aw_hs)
                     aw_got <= 1'b1;
                  if (w_hs)
                     w_got <= 1'b1;
                  if (ar_hs)
                     state <= S_RDATA;
               end
            end
            S_WRESP:
               if (bready)
                  state <= S_IDLE;
            S_RDATA:
               if (rready)
                  state <= S_IDLE;
            default:
               state <= S_IDLE;
         endcase
      end
   end

   // Hold the half of a write that came first, and the read data
   always_ff @(posedge clk)
   begin
      if (aw_hs)
         aw_q <= awaddr;
      if (w_hs)
         w_q <= wdata;
      if (ar_hs)
         rdata <= rd_data;
   end

endmodule

`default_nettype wire

/* hw/category_top.sv */
`timescale 1ns/1ps
`default_nettype none

module category_top (
   input  logic                     clk,
   input  logic                     rst_n,
   // Packet input
   input  logic                     in_valid,
   output logic                     in_ready,
   input  logic                     in_sop,
   input  logic                     in_eop,
   input  regex_pkg::char_t         in_char,
   input  stream_pkg::stream_id_t   in_stream,
   // Register port
   input  stream_pkg::csr_addr_t    awaddr,
   input  logic                     awvalid,
   output logic                     awready,
   input  stream_pkg::csr_data_t    wdata,
   input  logic                     wvalid,
   output logic                     wready,
   output logic [1:0]               bresp,
   output logic                     bvalid,
   input  logic                     bready,
   input  stream_pkg::csr_addr_t    araddr,
   input  logic                     arvalid,
   output logic                     arready,
   output stream_pkg::csr_data_t    rdata,
   output logic [1:0]               rresp,
   output logic                     rvalid,
   input  logic                     rready,
   // Status
   output stream_pkg::match_count_t count,
   output logic                     pkt_done,
   output logic                     pkt_hit,
   output stream_pkg::stream_id_t   pkt_stream
);
   import stream_pkg::*;

   enable_mask_t enable_mask;

   pkt_if u_pkt_if ();

   stream_tracker u_stream_tracker (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_sop    (in_sop),
      .in_eop    (in_eop),
      .in_char   (in_char),
      .in_stream (in_stream),
      .in_ready  (in_ready),
      .pkt       (u_pkt_if.src)
   );

   category_matcher u_category_matcher (
      .clk         (clk),
      .rst_n       (rst_n),
      .pkt         (u_pkt_if.dst),
      .enable_mask (enable_mask),
      .count       (count),
      .pkt_done    (pkt_done),
      .pkt_hit     (pkt_hit),
      .pkt_stream  (pkt_stream)
   );

   category_csr u_category_csr (
      .clk         (clk),
      .rst_n       (rst_n),
      .awaddr      (awaddr),
      .awvalid     (awvalid),
      .awready     (awready),
      .wdata       (wdata),
      .wvalid      (wvalid),
      .wready      (wready),
      .bresp       (bresp),
      .bvalid      (bvalid),
      .bready      (bready),
      .araddr      (araddr),
      .arvalid     (arvalid),
      .arready     (arready),
      .rdata       (rdata),
      .rresp       (rresp),
      .rvalid      (rvalid),
      .rready      (rready),
      .count       (count),
      .enable_mask (enable_mask)
   );

endmodule

`default_nettype wire

/* verif/tb_category_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_category_top;
   import regex_pkg::*;
   import stream_pkg::*;

   // Directed tests need about 400 cycles and 40 random packets of up to
   // 15 characters with about 10 cycles of overhead need under 1000
   localparam int TIMEOUT_CYCLES = 4000;
   // pkt_done is due three cycles after the eop beat
   localparam int DONE_WAIT = 6;
   localparam int RAND_PKTS = 40;
   localparam int unsigned SEED = 32'hc7cc;

   logic         clk;
   logic         rst_n;
   logic         in_valid;
   logic         in_ready;
   logic         in_sop;
   logic         in_eop;
   char_t        in_char;
   stream_id_t   in_stream;
   csr_addr_t    awaddr;
   logic         awvalid;
   logic         awready;
   csr_data_t    wdata;
   logic         wvalid;
   logic         wready;
   logic [1:0]   bresp;
   logic         bvalid;
   logic         bready;
   csr_addr_t    araddr;
   logic         arvalid;
   logic         arready;
   csr_data_t    rdata;
   logic [1:0]   rresp;
   logic         rvalid;
   logic         rready;
   match_count_t count;
   logic         pkt_done;
   logic         pkt_hit;
   stream_id_t   pkt_stream;

   // Reference model state
   dfa_state_t   model_state [NUM_STREAMS];
   logic         model_seen [NUM_STREAMS];
   enable_mask_t model_mask;
   match_count_t model_count;

   // Verdict of the latest packet as the DUT gave it
   logic         last_hit;
   stream_id_t   last_stream;

   int           value_errs = 0;
   int           other_errs = 0;
   int unsigned  cycle_cnt = 0;

   category_top u_category_top (.*);

   initial
      clk = 1'b0;
   always #2 clk = ~clk;

   // Run limit
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Value errors: %0d, other errors: %0d", value_errs, other_errs + 1);
         $display("Finished with errors");
         $finish;
      end
   end

   // Letter k of the keyword, k = 0 is the first
   function automatic char_t kw_letter(input int k);
      return KEYWORD[8*(KEYWORD_LEN-1-k) +: 8];
   endfunction

   // One DFA step as the keyword rules define it
   function automatic dfa_state_t dfa_step(input dfa_state_t s, input char_t c);
      int k;
      k = int'(s);
      // Full match steps on as from idle
      if (k >= KEYWORD_LEN)
         k = 0;
      if (c == kw_letter(k))
         return dfa_state_t'(k + 1);
      else if (c == kw_letter(0))
         return dfa_state_t'(1);
      return '0;
   endfunction

   // Filler drawn mostly from keyword letters so fragments line up now and then
   function automatic char_t random_filler();
      string alphabet = "torenxq";
      return char_t'(alphabet[int'($urandom % 7)]);
   endfunction

   task automatic check_count(input match_count_t got, input match_count_t exp,
                              input string what);
      if (got !== exp)
      begin
         value_errs++;
         $display("[FAIL] %0t: %s, count %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_hit(input logic got_hit, input logic exp_hit,
                            input stream_id_t got_stream, input stream_id_t exp_stream);
      if (got_hit !== exp_hit || got_stream !== exp_stream)
      begin
         value_errs++;
         $display("[FAIL] %0t: pkt_hit %b on stream %0d, expected %b on stream %0d",
                  $time, got_hit, got_stream, exp_hit, exp_stream);
      end
   endtask

   task automatic check_reg(input csr_data_t got, input csr_data_t exp, input string what);
      if (got !== exp)
      begin
         value_errs++;
         $display("[FAIL] %0t: %s, read 0x%08h expected 0x%08h", $time, what, got, exp);
      end
   endtask

   task automatic axi_write(input csr_addr_t addr, input csr_data_t data);
      logic aw_taken;
      logic w_taken;
      awaddr  = addr;
      awvalid = 1'b1;
      wdata   = data;
      wvalid  = 1'b1;
      while (awvalid || wvalid)
      begin
         // Ready is stable between edges, transfer on the next rising edge
         aw_taken = awvalid & awready;
         w_taken  = wvalid & wready;
         @(negedge clk);
         if (aw_taken)
            awvalid = 1'b0;
         if (w_taken)
            wvalid = 1'b0;
      end
      bready = 1'b1;
      while (!bvalid)
         @(negedge clk);
      if (bresp !== AXI_OKAY)
      begin
         other_errs++;
         $display("Write to 0x%02h returned response %b instead of OKAY", addr, bresp);
      end
      @(negedge clk);
      bready = 1'b0;
      // Mirror the enable registers
      if (addr == ADDR_EN_LO)
         model_mask[31:0] = data;
      else if (addr == ADDR_EN_HI)
         model_mask[63:32] = data;
   endtask

   task automatic axi_read(input csr_addr_t addr, output csr_data_t data);
      araddr  = addr;
      arvalid = 1'b1;
      while (!arready)
         @(negedge clk);
      @(negedge clk);
      arvalid = 1'b0;
      rready  = 1'b1;
      while (!rvalid)
         @(negedge clk);
      data = rdata;
      if (rresp !== AXI_OKAY)
      begin
         other_errs++;
         $display("Read of 0x%02h returned response %b instead of OKAY", addr, rresp);
      end
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic read_compare(input csr_addr_t addr, input csr_data_t exp, input string what);
      csr_data_t got;
      axi_read(addr, got);
      check_reg(got, exp, what);
   endtask

   // One input beat, waits for in_ready
   task automatic send_beat(input char_t c, input logic sop, input logic eop,
                            input stream_id_t sid);
      in_valid  = 1'b1;
      in_sop    = sop;
      in_eop    = eop;
      in_char   = c;
      in_stream = sid;
      while (!in_ready)
         @(negedge clk);
      @(negedge clk);
      in_valid = 1'b0;
      in_sop   = 1'b0;
      in_eop   = 1'b0;
   endtask

   // Sends a packet, checks its verdict and the counter against the model
   task automatic send_packet(input stream_id_t sid, input string text);
      dfa_state_t st;
      logic       hit;
      logic       exp_hit;
      int         wait_cnt;
      // Unseen streams start from zero
      st  = model_seen[sid] ? model_state[sid] : '0;
      hit = 1'b0;
      for (int i = 0; i < text.len(); i++)
      begin
         st = dfa_step(st, char_t'(text[i]));
         if (int'(st) == KEYWORD_LEN)
            hit = 1'b1;
         send_beat(char_t'(text[i]), i == 0, i == text.len() - 1, sid);
      end
      exp_hit = hit & model_mask[sid];
      model_seen[sid] = 1'b1;
      // Only enabled streams save state and count
      if (model_mask[sid])
      begin
         model_state[sid] = st;
         if (hit)
            model_count = model_count + 1'b1;
      end
      wait_cnt = 0;
      while (!pkt_done && wait_cnt < DONE_WAIT)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (pkt_done !== 1'b1)
      begin
         other_errs++;
         $display("pkt_done never came for the packet on stream %0d", sid);
      end
      else
      begin
         if (wait_cnt != 2)
         begin
            other_errs++;
            $display("pkt_done came %0d cycles after the eop beat, not 3", wait_cnt + 1);
         end
         last_hit    = pkt_hit;
         last_stream = pkt_stream;
         check_hit(pkt_hit, exp_hit, pkt_stream, sid);
      end
      @(negedge clk);
      check_count(count, model_count, "count after packet");
   endtask

   task automatic registers_access();
      if (pkt_done !== 1'b0 || bvalid !== 1'b0 || rvalid !== 1'b0 || in_ready !== 1'b0)
      begin
         other_errs++;
         $display("Outputs were not idle right after reset");
      end
      read_compare(ADDR_EN_LO, 32'h0, "enable low after reset");
      read_compare(ADDR_COUNT, 32'h0, "count after reset");
      // Streams 3 5 7 9 12 20 and 40 41 enabled
      axi_write(ADDR_EN_LO, 32'h0010_12a8);
      axi_write(ADDR_EN_HI, 32'h0000_0300);
      read_compare(ADDR_EN_LO, 32'h0010_12a8, "enable low readback");
      read_compare(ADDR_EN_HI, 32'h0000_0300, "enable high readback");
      // Unmapped and read only writes are ignored
      axi_write(8'h10, 32'hffff_ffff);
      axi_write(ADDR_COUNT, 32'h0000_1234);
      read_compare(8'h10, 32'h0, "unmapped address");
      read_compare(8'h0c, 32'h0, "unmapped address");
      read_compare(ADDR_EN_LO, 32'h0010_12a8, "enable low after stray writes");
      read_compare(ADDR_COUNT, 32'h0, "count is read only");
   endtask

   task automatic single_packet_match();
      send_packet(6'd3, "abtorrentxy");
      check_hit(last_hit, 1'b1, last_stream, 6'd3);
      check_count(count, 16'd1, "one keyword packet");
      send_packet(6'd3, "hello");
      check_hit(last_hit, 1'b0, last_stream, 6'd3);
   endtask

   task automatic cross_packet_match();
      send_packet(6'd5, "zzztor");
      // Other streams in between must not disturb stream 5
      send_packet(6'd9, "netor");
      send_packet(6'd12, "abc");
      send_packet(6'd5, "rentab");
      check_hit(last_hit, 1'b1, last_stream, 6'd5);
      send_packet(6'd9, "rent");
      check_hit(last_hit, 1'b1, last_stream, 6'd9);
      check_count(count, 16'd3, "after split keywords");
   endtask

   task automatic disabled_stream();
      // Known saved state of zero first
      send_packet(6'd20, "xyz");
      axi_write(ADDR_EN_LO, model_mask[31:0] & ~32'h0010_0000);
      send_packet(6'd20, "torrentxtor");
      check_hit(last_hit, 1'b0, last_stream, 6'd20);
      check_count(count, 16'd3, "disabled stream");
      axi_write(ADDR_EN_LO, model_mask[31:0] | 32'h0010_0000);
      // A saved "tor" would make this hit
      send_packet(6'd20, "rent");
      check_hit(last_hit, 1'b0, last_stream, 6'd20);
   endtask

   task automatic fallback_and_new_stream();
      send_packet(6'd7, "ttorrent");
      check_hit(last_hit, 1'b1, last_stream, 6'd7);
      // Stream 9 left partway, stream 40 is new
      send_packet(6'd9, "xtor");
      send_packet(6'd40, "rent");
      check_hit(last_hit, 1'b0, last_stream, 6'd40);
      send_packet(6'd41, "torrent");
      check_hit(last_hit, 1'b1, last_stream, 6'd41);
      check_count(count, 16'd5, "after fallback tests");
   endtask

   task automatic random_traffic();
      string      text;
      stream_id_t sid;
      int         first;
      int         last;
      int         n;
      // Streams 56 to 63 are still unseen, 56 stays on and 63 stays off
      axi_write(ADDR_EN_HI, ($urandom | 32'h0100_0000) & ~32'h8000_0000);
      for (int p = 0; p < RAND_PKTS; p++)
      begin
         sid  = stream_id_t'(56 + ($urandom % 8));
         text = "";
         n    = int'($urandom % 5);
         for (int i = 0; i < n; i++)
            text = $sformatf("%s%c", text, random_filler());
         // Half the packets carry a piece of the keyword
         if ($urandom % 2 == 1)
         begin
            first = int'($urandom % KEYWORD_LEN);
            last  = first + int'($urandom % (KEYWORD_LEN - first));
            for (int i = first; i <= last; i++)
               text = $sformatf("%s%c", text, kw_letter(i));
         end
         n = int'($urandom % 5);
         for (int i = 0; i < n; i++)
            text = $sformatf("%s%c", text, random_filler());
         if (text.len() == 0)
            text = "x";
         send_packet(sid, text);
      end
      check_count(count, model_count, "count after random traffic");
      read_compare(ADDR_COUNT, csr_data_t'(model_count), "count register after random traffic");
   endtask

   initial
   begin
      $timeformat(-9, 0, " ns", 0);
      void'($urandom(SEED));
      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_sop    = 1'b0;
      in_eop    = 1'b0;
      in_char   = '0;
      in_stream = '0;
      awaddr    = '0;
      awvalid   = 1'b0;
      wdata     = '0;
      wvalid    = 1'b0;
      bready    = 1'b0;
      araddr    = '0;
      arvalid   = 1'b0;
      rready    = 1'b0;
      for (int s = 0; s < NUM_STREAMS; s++)
      begin
         model_state[s] = '0;
         model_seen[s]  = 1'b0;
      end
      model_mask  = '0;
      model_count = '0;
      last_hit    = 1'b0;
      last_stream = '0;
      repeat (4)
         @(negedge clk);
      rst_n = 1'b1;

      registers_access();
      single_packet_match();
      cross_packet_match();
      disabled_stream();
      fallback_and_new_stream();
      random_traffic();

      $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
hw/regex_pkg.sv
hw/stream_pkg.sv
hw/pkt_if.sv
hw/keyword_dfa.sv
hw/category_matcher.sv
hw/stream_tracker.sv
hw/category_csr.sv
hw/category_top.sv
verif/tb_category_top.sv

/* run.sh */
#!/bin/sh
# Build and run the category_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
   -f files.f --top-module tb_category_top -o tb_category_top
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/tb_category_top)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# The run passes only if the pass line was printed
if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1
